/* Bender.yml */
package:
  name: uart_fifo

sources:
  - src/uart_pkg.sv
  - src/sync_fifo.sv
  - src/uart_tx.sv
  - src/uart_rx.sv
  - src/uart_fifo.sv
  - target: test
    files:
      - tb/uart_checker.sv
      - tb/tb_uart_fifo.sv

/* src/sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo #(
    parameter int SIZE_BITS = 7
) (
    input  logic                   clk,
    input  logic                   nreset,
    input  logic                   rreq,
    output logic                   rack,
    input  logic                   wreq,
    output logic                   wack,
    input  uart_pkg::byte_t        data_in,
    output uart_pkg::byte_t        data_out,
    output uart_pkg::fifo_status_t status
);

    localparam logic [SIZE_BITS:0] DEPTH = (SIZE_BITS + 1)'(1) << SIZE_BITS;

    uart_pkg::byte_t      mem [0:DEPTH-1];
    logic [SIZE_BITS-1:0] rptr;
    logic [SIZE_BITS-1:0] wptr;
    logic [SIZE_BITS:0]   count;
    logic                 do_read;
    logic                 do_write;

    assign status = '{full: (count == DEPTH), empty: (count == '0)};

    // a request still high in its ack cycle is not served twice.
    assign do_read  = rreq && !rack && !status.empty;
    assign do_write = wreq && !wack && !status.full;

    always_ff @(posedge clk) begin
        if (!nreset) begin
            rack  <= 1'b0;
            wack  <= 1'b0;
            rptr  <= '0;
            wptr  <= '0;
            count <= '0;
        end else begin
            rack <= do_read;
            wack <= do_write;
            if (do_read)
                rptr <= rptr + 1'b1;
            if (do_write)
                wptr <= wptr + 1'b1;
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // none, or both at once.
            endcase
        end
    end

    // storage and read data.
    always_ff @(posedge clk) begin
        if (do_write)
            mem[wptr] <= data_in;
        if (do_read)
            data_out <= mem[rptr];
    end

endmodule

/* src/uart_fifo.sv */
`timescale 1ns/1ps

module uart_fifo #(
    parameter int CLOCK_DIV          = 234,  // 27 MHz clock, 115200 baud.
    parameter int CLOCK_COUNTER_BITS = 8,
    parameter int RX_FIFO_BITS       = 7,
    parameter int TX_FIFO_BITS       = 7
) (
    input  logic            clk,
    input  logic            nreset,
    output logic            tx,
    input  logic            rx,
    input  logic            req,
    input  logic            nwr,
    input  uart_pkg::byte_t data_in,
    output uart_pkg::byte_t data_out,
    output logic            full,
    output logic            empty,
    output logic            ack
);

    uart_pkg::host_req_t    host;
    uart_pkg::fifo_status_t rx_status;
    uart_pkg::fifo_status_t tx_status;
    uart_pkg::byte_t        tx_data;
    uart_pkg::byte_t        rx_data;
    logic rack, wack;
    logic tx_fifo_rreq, tx_fifo_rack;
    logic rx_fifo_wreq, rx_fifo_wack;
    logic send, busy, done;
    logic in_flight;

    assign host  = '{req: req, nwr: nwr, data: data_in};
    assign ack   = rack | wack;
    assign full  = tx_status.full;
    assign empty = rx_status.empty;

    sync_fifo #(.SIZE_BITS(RX_FIFO_BITS)) rx_fifo (
        .clk(clk), .nreset(nreset),
        .rreq(host.req & host.nwr), .rack(rack),
        .wreq(rx_fifo_wreq), .wack(rx_fifo_wack),
        .data_in(rx_data), .data_out(data_out), .status(rx_status)
    );

    sync_fifo #(.SIZE_BITS(TX_FIFO_BITS)) tx_fifo (
        .clk(clk), .nreset(nreset),
        .rreq(tx_fifo_rreq), .rack(tx_fifo_rack),
        .wreq(host.req & ~host.nwr), .wack(wack),
        .data_in(host.data), .data_out(tx_data), .status(tx_status)
    );

    uart_tx #(.CLOCK_DIV(CLOCK_DIV), .CLOCK_COUNTER_BITS(CLOCK_COUNTER_BITS)) i_tx (
        .clk(clk), .nreset(nreset), .data(tx_data), .send(send), .tx(tx), .busy(busy)
    );

    uart_rx #(.CLOCK_DIV(CLOCK_DIV), .CLOCK_COUNTER_BITS(CLOCK_COUNTER_BITS)) i_rx (
        .clk(clk), .nreset(nreset), .rx(rx), .data(rx_data), .done(done)
    );

    // pop and send are pending until busy comes up.
    assign in_flight = tx_fifo_rreq | tx_fifo_rack | send;

    // ~~~~~~~~~~~~~~~~~~~~
    // transfer glue.
    always_ff @(posedge clk) begin
        if (!nreset) begin
            tx_fifo_rreq <= 1'b0;
            send         <= 1'b0;
            rx_fifo_wreq <= 1'b0;
        end else begin
            send <= tx_fifo_rack;  // byte is on tx_data now.
            if (tx_fifo_rack)
                tx_fifo_rreq <= 1'b0;
            else if (!busy && !in_flight && !tx_status.empty)
                tx_fifo_rreq <= 1'b1;

            // received byte is lost when the fifo is full.
            if (rx_fifo_wack)
                rx_fifo_wreq <= 1'b0;
            else if (done && !rx_status.full)
                rx_fifo_wreq <= 1'b1;
        end
    end

endmodule

/* src/uart_pkg.sv */
package uart_pkg;

    typedef logic [7:0] byte_t;

    // fifo flags, as reported by each sync_fifo.
    typedef struct packed {
        logic full;
        logic empty;
    } fifo_status_t;

    // host side request.
    typedef struct packed {
        logic  req;
        logic  nwr;  // high for a read.
        byte_t data;
    } host_req_t;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

endpackage

/* src/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx #(
    parameter int CLOCK_DIV          = 234,
    parameter int CLOCK_COUNTER_BITS = 8
) (
    input  logic            clk,
    input  logic            nreset,
    input  logic            rx,
    output uart_pkg::byte_t data,
    output logic            done
);

    localparam logic [CLOCK_COUNTER_BITS-1:0] HALF = CLOCK_COUNTER_BITS'(CLOCK_DIV / 2 - 1);
    localparam logic [CLOCK_COUNTER_BITS-1:0] LAST = CLOCK_COUNTER_BITS'(CLOCK_DIV - 1);

    uart_pkg::rx_state_t           state;
    logic [CLOCK_COUNTER_BITS-1:0] count;
    logic [2:0]                    bit_idx;
    uart_pkg::byte_t               shift;
    logic                          rx_meta;
    logic                          rx_sync;
    logic                          rx_last;

    assign data = shift;

    // ~~~~~~~~~~~~~~~~~~~~
    // input synchronizer.
    always_ff @(posedge clk) begin
        if (!nreset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_last <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_last <= rx_sync;  // for edge detect.
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // frame sequencer.
    always_ff @(posedge clk) begin
        if (!nreset) begin
            state   <= uart_pkg::RX_IDLE;
            count   <= '0;
            bit_idx <= '0;
            done    <= 1'b0;
        end else begin
            done  <= 1'b0;
            count <= (count == LAST) ? '0 : count + 1'b1;
            case (state)
                uart_pkg::RX_IDLE: begin
                    count <= '0;
                    if (rx_last && !rx_sync)
                        state <= uart_pkg::RX_START;
                end
                uart_pkg::RX_START:
                    if (count == HALF) begin
                        count   <= '0;  // now aligned to bit centres.
                        bit_idx <= '0;
                        state   <= rx_sync ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
                    end
                uart_pkg::RX_DATA:
                    if (count == LAST) begin
                        shift   <= {rx_sync, shift[7:1]};  // lsb arrives first.
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7)
                            state <= uart_pkg::RX_STOP;
                    end
                uart_pkg::RX_STOP:
                    if (count == LAST) begin
                        done  <= rx_sync;  // low stop bit drops the frame.
                        state <= uart_pkg::RX_IDLE;
                    end
                default: state <= uart_pkg::RX_IDLE;
            endcase
        end
    end

endmodule

/* src/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx #(
    parameter int CLOCK_DIV          = 234,
    parameter int CLOCK_COUNTER_BITS = 8
) (
    input  logic            clk,
    input  logic            nreset,
    input  uart_pkg::byte_t data,
    input  logic            send,
    output logic            tx,
    output logic            busy
);

    localparam logic [CLOCK_COUNTER_BITS-1:0] LAST = CLOCK_COUNTER_BITS'(CLOCK_DIV - 1);

    uart_pkg::tx_state_t           state;
    logic [CLOCK_COUNTER_BITS-1:0] count;
    logic [2:0]                    bit_idx;
    uart_pkg::byte_t               shift;

    assign busy = (state != uart_pkg::TX_IDLE);

    always_ff @(posedge clk) begin
        if (!nreset) begin
            state   <= uart_pkg::TX_IDLE;
            tx      <= 1'b1;
            count   <= '0;
            bit_idx <= '0;
        end else begin
            count <= (count == LAST) ? '0 : count + 1'b1;
            case (state)
                uart_pkg::TX_IDLE: begin
                    count <= '0;
                    if (send) begin
                        shift <= data;
                        tx    <= 1'b0;  // start bit.
                        state <= uart_pkg::TX_START;
                    end
                end
                uart_pkg::TX_START:
                    if (count == LAST) begin
                        tx      <= shift[0];
                        shift   <= shift >> 1;
                        bit_idx <= '0;
                        state   <= uart_pkg::TX_DATA;
                    end
                uart_pkg::TX_DATA:
                    if (count == LAST) begin
                        bit_idx <= bit_idx + 1'b1;
                        tx      <= (bit_idx == 3'd7) ? 1'b1 : shift[0];
                        shift   <= shift >> 1;
                        if (bit_idx == 3'd7)
                            state <= uart_pkg::TX_STOP;
                    end
                uart_pkg::TX_STOP:
                    if (count == LAST)
                        state <= uart_pkg::TX_IDLE;
                default: state <= uart_pkg::TX_IDLE;
            endcase
        end
    end

endmodule

/* tb/tb_uart_fifo.sv */
`timescale 1ns/1ps

module tb_uart_fifo;

    localparam int CLOCK_DIV          = 8;
    localparam int CLOCK_COUNTER_BITS = 4;
    localparam int TX_FIFO_BITS       = 2;
    localparam int RX_FIFO_BITS       = 2;
    localparam int FRAME_CYCLES       = 10 * CLOCK_DIV;
    localparam int TX_DEPTH           = 1 << TX_FIFO_BITS;
    localparam int RX_DEPTH           = 1 << RX_FIFO_BITS;
    localparam int TABLE_LEN          = 9;
    localparam int WATCHDOG_CYCLES    = TABLE_LEN * 12 * FRAME_CYCLES + 100;
    localparam int DRAIN_CYCLES       = (TX_DEPTH + 2) * (FRAME_CYCLES + 4);

    typedef enum logic [1:0] {LOOPBACK, BURST_WRITE, BAD_STOP, OVERFLOW_FILL} mode_t;

    typedef struct packed {
        mode_t           mode;
        uart_pkg::byte_t data;
        uart_pkg::byte_t expect_val;
    } stim_t;

    logic            clk = 1'b0;
    logic            nreset;
    logic            req;
    logic            nwr;
    uart_pkg::byte_t data_in;
    uart_pkg::byte_t data_out;
    uart_pkg::byte_t exp_read;
    logic            full;
    logic            empty;
    logic            ack;
    logic            tx;
    logic            rx;
    logic            loop_sel;  // 1 ties rx to tx.
    logic            line_drv;
    int unsigned     cycle = 0;
    stim_t           stim [0:TABLE_LEN-1];

    assign rx = loop_sel ? tx : line_drv;

    uart_fifo #(
        .CLOCK_DIV(CLOCK_DIV), .CLOCK_COUNTER_BITS(CLOCK_COUNTER_BITS),
        .RX_FIFO_BITS(RX_FIFO_BITS), .TX_FIFO_BITS(TX_FIFO_BITS)
    ) i_dut (
        .clk(clk), .nreset(nreset), .tx(tx), .rx(rx), .req(req), .nwr(nwr),
        .data_in(data_in), .data_out(data_out), .full(full), .empty(empty), .ack(ack)
    );

    uart_checker #(.CLOCK_DIV(CLOCK_DIV)) i_chk (
        .clk(clk), .nreset(nreset), .tx(tx), .nwr(nwr), .data_in(data_in),
        .data_out(data_out), .ack(ack), .full(full), .empty(empty), .exp_read(exp_read)
    );

    always #20 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    // ~~~~~~~~~~~~~~~~~~~~
    // host bus and serial line.
    task automatic host_write(input uart_pkg::byte_t value);
        req     = 1'b1;
        nwr     = 1'b0;
        data_in = value;
        @(negedge clk);
        while (!ack) @(negedge clk);  // waits out back-pressure.
        req = 1'b0;
    endtask

    task automatic host_read(input uart_pkg::byte_t expected);
        req      = 1'b1;
        nwr      = 1'b1;
        exp_read = expected;
        @(negedge clk);
        while (!ack) @(negedge clk);
        req = 1'b0;
    endtask

    task automatic send_frame(input uart_pkg::byte_t value, input logic stop_bit);
        line_drv = 1'b0;
        repeat (CLOCK_DIV) @(negedge clk);
        for (int i = 0; i < 8; i++) begin
            line_drv = value[i];
            repeat (CLOCK_DIV) @(negedge clk);
        end
        line_drv = stop_bit;
        repeat (CLOCK_DIV) @(negedge clk);
        line_drv = 1'b1;
        repeat (2 * CLOCK_DIV) @(negedge clk);  // idle gap.
    endtask

    task automatic wait_tx_drained();
        int unsigned waited;
        waited = 0;
        @(negedge clk);
        while (i_chk.frames_pending != 0 && waited < DRAIN_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        repeat (CLOCK_DIV) @(negedge clk);  // rest of the stop bit.
        i_chk.check_drained();
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // table modes.
    task automatic run_burst(input uart_pkg::byte_t count);
        int unsigned first_ack;
        logic [31:0] rnd;
        loop_sel = 1'b0;
        for (int n = 0; n < count; n++) begin
            rnd = $urandom;
            host_write(rnd[7:0]);
            if (n == 0)
                first_ack = cycle;
        end
        if (count > TX_DEPTH)
            i_chk.check_flags(1'b1, 1'b1);
        rnd = $urandom;
        host_write(rnd[7:0]);
        i_chk.check_ack_gap(cycle - first_ack, FRAME_CYCLES + 4);
        wait_tx_drained();
    endtask

    task automatic run_bad_stop(input uart_pkg::byte_t bad, input uart_pkg::byte_t good);
        loop_sel = 1'b0;
        send_frame(bad, 1'b0);
        send_frame(good, 1'b1);
        host_read(good);
        i_chk.check_flags(1'b0, 1'b1);
    endtask

    task automatic run_overflow(input uart_pkg::byte_t base, input uart_pkg::byte_t first);
        uart_pkg::byte_t value;
        loop_sel = 1'b0;
        value    = base;
        for (int n = 0; n < RX_DEPTH + 2; n++) begin
            send_frame(value, 1'b1);
            value = value + 8'd1;
        end
        value = first;
        for (int n = 0; n < RX_DEPTH; n++) begin  // last two frames were dropped.
            host_read(value);
            value = value + 8'd1;
        end
        i_chk.check_flags(1'b0, 1'b1);
    endtask

    task automatic apply_entry(input stim_t entry);
        case (entry.mode)
            LOOPBACK: begin
                loop_sel = 1'b1;
                host_write(entry.data);
                while (empty) @(negedge clk);
                host_read(entry.expect_val);
            end
            BURST_WRITE:   run_burst(entry.data);
            BAD_STOP:      run_bad_stop(entry.data, entry.expect_val);
            OVERFLOW_FILL: run_overflow(entry.data, entry.expect_val);
            default: ;
        endcase
    endtask

    function automatic stim_t make_entry(input mode_t mode, input uart_pkg::byte_t data,
                                         input uart_pkg::byte_t expect_val);
        stim_t entry;
        entry.mode       = mode;
        entry.data       = data;
        entry.expect_val = expect_val;
        return entry;
    endfunction

    task automatic load_table();
        stim[0] = make_entry(LOOPBACK, 8'h55, 8'h55);
        stim[1] = make_entry(LOOPBACK, 8'h00, 8'h00);
        stim[2] = make_entry(LOOPBACK, 8'hff, 8'hff);
        stim[3] = make_entry(LOOPBACK, 8'ha5, 8'ha5);
        stim[4] = make_entry(LOOPBACK, 8'h01, 8'h01);
        stim[5] = make_entry(LOOPBACK, 8'h80, 8'h80);
        stim[6] = make_entry(BURST_WRITE, 8'd5, 8'h00);  // data holds the write count.
        stim[7] = make_entry(BAD_STOP, 8'h3c, 8'hc3);
        stim[8] = make_entry(OVERFLOW_FILL, 8'h10, 8'h10);
    endtask

    task automatic finish_run();
        $display("error counts: %0d mismatches, %0d other failures",
                 i_chk.mismatches, i_chk.failures);
        if (i_chk.mismatches == 0 && i_chk.failures == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    initial begin
        nreset    = 1'b0;
        req       = 1'b0;
        nwr       = 1'b0;
        data_in   = '0;
        exp_read  = '0;
        loop_sel  = 1'b0;
        line_drv  = 1'b1;
        void'($urandom(44668));
        load_table();
        repeat (16) @(negedge clk);
        nreset = 1'b1;
        @(negedge clk);
        i_chk.check_idle();
        for (int k = 0; k < TABLE_LEN; k++)
            apply_entry(stim[k]);
        wait_tx_drained();
        finish_run();
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        i_chk.report_failure($sformatf("watchdog timeout after %0d cycles", WATCHDOG_CYCLES));
        finish_run();
    end

endmodule

/* tb/uart_checker.sv */
`timescale 1ns/1ps

module uart_checker #(
    parameter int CLOCK_DIV = 8
) (
    input logic            clk,
    input logic            nreset,
    input logic            tx,
    input logic            nwr,
    input uart_pkg::byte_t data_in,
    input uart_pkg::byte_t data_out,
    input logic            ack,
    input logic            full,
    input logic            empty,
    input uart_pkg::byte_t exp_read
);

    int              mismatches     = 0;
    int              failures       = 0;
    int              frames_pending = 0;
    uart_pkg::byte_t tx_queue [$];  // written bytes still to appear on tx.
    logic            nwr_q;
    uart_pkg::byte_t data_in_q;
    uart_pkg::byte_t exp_q;
    logic            tx_prev;

    task automatic compare_value(input string name, input logic [7:0] expected,
                                 input logic [7:0] actual);
        if (actual !== expected) begin
            mismatches++;
            $display("MISMATCH at %0d ns: %s expected %h, actual %h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic report_failure(input string what);
        failures++;
        $display("ERROR at %0d ns: %s", $time, what);
    endtask

    task automatic check_idle();
        compare_value("tx", 8'd1, {7'd0, tx});
        compare_value("empty", 8'd1, {7'd0, empty});
        compare_value("full", 8'd0, {7'd0, full});
        compare_value("ack", 8'd0, {7'd0, ack});
    endtask

    task automatic check_flags(input logic exp_full, input logic exp_empty);
        compare_value("full", {7'd0, exp_full}, {7'd0, full});
        compare_value("empty", {7'd0, exp_empty}, {7'd0, empty});
    endtask

    task automatic check_ack_gap(input int gap, input int min_gap);
        if (gap < min_gap)
            report_failure($sformatf("write to a full TX FIFO acknowledged after %0d cycles, %s %0d",
                                     gap, "before the first frame ended at", min_gap));
    endtask

    task automatic check_drained();
        if (tx_queue.size() != 0)
            report_failure($sformatf("%0d written bytes never appeared on tx", tx_queue.size()));
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // host transfers, seen one cycle after the request was sampled.
    always @(posedge clk) begin
        if (nreset && ack) begin
            if (nwr_q)
                compare_value("data_out", exp_q, data_out);
            else begin
                tx_queue.push_back(data_in_q);
                frames_pending = tx_queue.size();
            end
        end
        nwr_q     = nwr;
        data_in_q = data_in;
        exp_q     = exp_read;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // tx frame decoder, samples at bit centres.
    task automatic decode_frame();
        uart_pkg::byte_t bits;
        uart_pkg::byte_t expected;
        repeat (CLOCK_DIV / 2 - 1) @(posedge clk);
        compare_value("tx start bit", 8'd0, {7'd0, tx});
        for (int i = 0; i < 8; i++) begin
            repeat (CLOCK_DIV) @(posedge clk);
            bits[i] = tx;  // lsb first.
        end
        repeat (CLOCK_DIV) @(posedge clk);
        compare_value("tx stop bit", 8'd1, {7'd0, tx});
        if (tx_queue.size() == 0)
            report_failure($sformatf("frame %h on tx with no byte written", bits));
        else begin
            expected       = tx_queue.pop_front();
            frames_pending = tx_queue.size();
            compare_value("tx frame data", expected, bits);
        end
    endtask

    initial begin
        tx_prev = 1'b1;
        forever begin
            @(posedge clk);
            if (nreset && tx_prev && !tx) begin
                decode_frame();
                tx_prev = 1'b1;
            end else
                tx_prev = tx;
        end
    end

endmodule

/* verilog.f */
src/uart_pkg.sv
src/sync_fifo.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart_fifo.sv
tb/uart_checker.sv
tb/tb_uart_fifo.sv
